// File: perfPkg.sv
/* Performance monitor shared types */

`default_nettype none

package perfPkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // one bit per core event
  localparam int NumEvents     = 8;
  localparam int CountWidth    = 32;
  localparam int PcWidth       = 32;
  // trace buffer depth and pointer size
  localparam int TraceDepth    = 16;
  localparam int TracePtrWidth = 4;
  // selects one delta register out of NumEvents
  localparam int DeltaIdxWidth = $clog2(NumEvents);

  //////////////////////////////
  // register map
  //////////////////////////////

  localparam logic [7:0] AddrStatus    = 8'h00;
  localparam logic [7:0] AddrPop       = 8'h04;
  localparam logic [7:0] AddrPeek      = 8'h08;
  localparam logic [7:0] AddrDeltaBase = 8'h40;

  // plain vector types
  typedef logic [CountWidth-1:0]  countT;
  typedef logic [PcWidth-1:0]     pcT;
  typedef logic [NumEvents-1:0]   eventVecT;
  typedef logic [7:0]             apbAddrT;
  typedef logic [31:0]            apbDataT;
  // one extra bit so a full buffer can be told from an empty one
  typedef logic [TracePtrWidth:0] traceCountT;

  // kind field of a trace entry
  typedef enum logic [1:0] {
    kindTrain  = 2'd0,
    kindBegin  = 2'd1,
    kindBranch = 2'd2,
    kindEnd    = 2'd3
  } traceKindT;

  //////////////////////////////
  // bundles
  //////////////////////////////

  typedef struct packed {
    logic valid;
    logic taken;
    pcT   pc;
  } branchRetireT;

  typedef struct packed {
    traceKindT kind;
    logic      taken;
    pcT        pc;
  } traceRecT;

  typedef struct packed {
    logic startPulse;
    logic endPulse;
    logic windowOpen;
    logic trainPulse;
  } windowCtlT;

  typedef struct packed {
    logic    psel;
    logic    penable;
    logic    pwrite;
    apbAddrT paddr;
    apbDataT pwdata;
  } apbReqT;

  typedef struct packed {
    apbDataT prdata;
    logic    pready;
    logic    pslverr;
  } apbRspT;

endpackage

`default_nettype wire

// File: sampleWindow.sv
/* Sampling window control */

`timescale 1ns/1ps
`default_nettype none

module sampleWindow (
  input  wire logic              clk,
  input  wire logic              resetEdge,
  input  wire logic              startTrigger,
  input  wire logic              stopTrigger,
  output perfPkg::windowCtlT     windowCtl
);

  // delayed copies for edge detection
  logic startD;
  logic stopD;
  logic resetD;
  logic windowOpen;
  logic startPulse;
  logic endPulse;
  logic trainPulse;

  always_ff @(posedge clk) begin
    if (resetEdge) begin
      startD     <= 1'b0;
      stopD      <= 1'b0;
      windowOpen <= 1'b0;
    end else begin
      startD <= startTrigger;
      stopD  <= stopTrigger;
      // open on start, close on stop
      if (startPulse) begin
        windowOpen <= 1'b1;
      end else if (endPulse) begin
        windowOpen <= 1'b0;
      end
    end
  end

  // delayed reset for the train pulse
  always_ff @(posedge clk) begin
    resetD <= resetEdge;
  end

  // rising edges, gated by the current window state
  assign startPulse = startTrigger & ~startD & ~windowOpen;
  assign endPulse   = stopTrigger & ~stopD & windowOpen;
  // first cycle out of reset
  assign trainPulse = ~resetEdge & resetD;

  assign windowCtl = '{startPulse: startPulse, endPulse: endPulse,
                       windowOpen: windowOpen, trainPulse: trainPulse};

  //////////////////////////////
  // checks
  //////////////////////////////

  aStartEndExclusive: assert property (@(posedge clk) disable iff (resetEdge)
    !(startPulse && endPulse))
    else $error("start and end pulse in the same cycle");

endmodule

`default_nettype wire

// File: eventCounters.sv
/* Event counters and window deltas */

`timescale 1ns/1ps
`default_nettype none

module eventCounters (
  input  wire logic               clk,
  input  wire logic               resetEdge,
  input  perfPkg::eventVecT       events,
  input  perfPkg::windowCtlT      windowCtl,
  output perfPkg::countT          deltas [perfPkg::NumEvents]
);

  // free-running totals since reset
  perfPkg::countT counters [perfPkg::NumEvents];
  // totals seen at window start
  perfPkg::countT snapshot [perfPkg::NumEvents];
  // per-event counts over the last closed window
  perfPkg::countT deltaReg [perfPkg::NumEvents];

  //////////////////////////////
  // counting
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (resetEdge) begin
      for (int i = 0; i < perfPkg::NumEvents; i++) begin
        counters[i] <= '0;
      end
    end else begin
      // each counter takes its event bit every cycle
      for (int i = 0; i < perfPkg::NumEvents; i++) begin
        counters[i] <= counters[i] + perfPkg::countT'(events[i]);
      end
    end
  end

  // snapshot holds the count before the start cycle
  always_ff @(posedge clk) begin
    if (windowCtl.startPulse) begin
      for (int i = 0; i < perfPkg::NumEvents; i++) begin
        snapshot[i] <= counters[i];
      end
    end
  end

  //////////////////////////////
  // deltas
  //////////////////////////////

  // counter in the end cycle excludes that cycle's event
  always_ff @(posedge clk) begin
    if (resetEdge) begin
      for (int i = 0; i < perfPkg::NumEvents; i++) begin
        deltaReg[i] <= '0;
      end
    end else if (windowCtl.endPulse) begin
      for (int i = 0; i < perfPkg::NumEvents; i++) begin
        deltaReg[i] <= counters[i] - snapshot[i];
      end
    end
  end

  assign deltas = deltaReg;

  // checks
  aEndInsideWindow: assert property (@(posedge clk) disable iff (resetEdge)
    windowCtl.endPulse |-> windowCtl.windowOpen)
    else $error("end pulse with window closed");

  // snapshot is only taken with the window closed
  aStartOutsideWindow: assert property (@(posedge clk) disable iff (resetEdge)
    windowCtl.startPulse |-> !windowCtl.windowOpen)
    else $error("start pulse with window open");

endmodule

`default_nettype wire

// File: branchTrace.sv
/* Branch and marker trace buffer */

`timescale 1ns/1ps
`default_nettype none

module branchTrace (
  input  wire logic               clk,
  input  wire logic               resetEdge,
  input  perfPkg::windowCtlT      windowCtl,
  input  perfPkg::branchRetireT   branchRetire,
  input  wire logic               pop,
  input  wire logic               clearOverflow,
  output perfPkg::traceRecT       head,
  output perfPkg::traceCountT     occupancy,
  output logic                    overflow
);

  perfPkg::traceRecT  mem [perfPkg::TraceDepth];
  logic [perfPkg::TracePtrWidth-1:0] wrPtr;
  logic [perfPkg::TracePtrWidth-1:0] rdPtr;
  perfPkg::traceCountT count;
  perfPkg::traceRecT  rec;
  logic recValid;
  logic full;
  logic empty;
  logic push;
  logic doPop;

  //////////////////////////////
  // record select
  //////////////////////////////

  // markers win over branches, train first
  always_comb begin
    rec      = '{kind: perfPkg::kindBranch, taken: 1'b0, pc: '0};
    recValid = 1'b1;
    if (windowCtl.trainPulse) begin
      rec.kind = perfPkg::kindTrain;
    end else if (windowCtl.startPulse) begin
      rec.kind = perfPkg::kindBegin;
    end else if (windowCtl.endPulse) begin
      rec.kind = perfPkg::kindEnd;
    end else if (branchRetire.valid && windowCtl.windowOpen) begin
      rec.taken = branchRetire.taken;
      rec.pc    = branchRetire.pc;
    end else begin
      recValid = 1'b0;
    end
  end

  assign full  = (count == perfPkg::traceCountT'(perfPkg::TraceDepth));
  assign empty = (count == '0);
  // a record offered when full is lost
  assign push  = recValid & ~full;
  assign doPop = pop & ~empty;

  //////////////////////////////
  // fifo
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= rec;
    end
  end

  // pointers wrap on their own at depth 16
  always_ff @(posedge clk) begin
    if (resetEdge) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      count <= count + perfPkg::traceCountT'(push) - perfPkg::traceCountT'(doPop);
    end
  end

  // sticky drop flag, a new drop beats a clear
  always_ff @(posedge clk) begin
    if (resetEdge) begin
      overflow <= 1'b0;
    end else if (recValid && full) begin
      overflow <= 1'b1;
    end else if (clearOverflow) begin
      overflow <= 1'b0;
    end
  end

  // fall-through head
  assign head      = mem[rdPtr];
  assign occupancy = count;

  // checks
  aNoEmptyPop: assert property (@(posedge clk) disable iff (resetEdge)
    pop |-> !empty)
    else $error("pop from empty trace buffer");

  aCountBound: assert property (@(posedge clk) disable iff (resetEdge)
    count <= perfPkg::traceCountT'(perfPkg::TraceDepth))
    else $error("trace occupancy above depth");

endmodule

`default_nettype wire

// File: apbRegs.sv
/* APB register block */

`timescale 1ns/1ps
`default_nettype none

module apbRegs (
  input  wire logic              clk,
  input  wire logic              resetEdge,
  input  perfPkg::apbReqT        apbReq,
  output perfPkg::apbRspT        apbRsp,
  input  wire logic              windowOpen,
  input  perfPkg::countT         deltas [perfPkg::NumEvents],
  input  perfPkg::traceRecT      head,
  input  perfPkg::traceCountT    occupancy,
  input  wire logic              overflow,
  output logic                   pop,
  output logic                   clearOverflow
);

  logic access;
  logic traceEmpty;
  logic deltaHit;
  perfPkg::apbAddrT deltaOffset;
  logic [perfPkg::DeltaIdxWidth-1:0] deltaIdx;
  perfPkg::apbDataT rdata;
  logic err;

  // access phase, pready is always high so it lasts one cycle
  assign access     = apbReq.psel & apbReq.penable;
  assign traceEmpty = (occupancy == '0);

  //////////////////////////////
  // delta window decode
  //////////////////////////////

  // below the base the offset wraps high and misses
  assign deltaOffset = apbReq.paddr - perfPkg::AddrDeltaBase;
  assign deltaHit    = (deltaOffset < perfPkg::apbAddrT'(4 * perfPkg::NumEvents)) &&
                       (deltaOffset[1:0] == 2'b00);
  assign deltaIdx    = deltaOffset[2 +: perfPkg::DeltaIdxWidth];

  //////////////////////////////
  // access decode
  //////////////////////////////

  always_comb begin
    rdata         = '0;
    err           = 1'b0;
    pop           = 1'b0;
    clearOverflow = 1'b0;
    if (access) begin
      if (apbReq.pwrite) begin
        // status is the only writable address
        if (apbReq.paddr == perfPkg::AddrStatus) begin
          clearOverflow = apbReq.pwdata[1];
        end else begin
          err = 1'b1;
        end
      end else begin
        if (apbReq.paddr == perfPkg::AddrStatus) begin
          // occupancy from bit 8 up
          rdata = perfPkg::apbDataT'({occupancy, 6'b0, overflow, windowOpen});
        end else if (apbReq.paddr == perfPkg::AddrPop) begin
          if (traceEmpty) begin
            err = 1'b1;
          end else begin
            rdata = perfPkg::apbDataT'({head.taken, head.kind});
            pop   = 1'b1;
          end
        end else if (apbReq.paddr == perfPkg::AddrPeek) begin
          // pc of the head, no pop
          if (traceEmpty) begin
            err = 1'b1;
          end else begin
            rdata = perfPkg::apbDataT'(head.pc);
          end
        end else if (deltaHit) begin
          rdata = perfPkg::apbDataT'(deltas[deltaIdx]);
        end else begin
          // unmapped reads give zero data
          err = 1'b1;
        end
      end
    end
  end

  assign apbRsp = '{prdata: rdata, pready: 1'b1, pslverr: err};

  //////////////////////////////
  // protocol checks
  //////////////////////////////

  aEnableNeedsSel: assert property (@(posedge clk) disable iff (resetEdge)
    apbReq.penable |-> apbReq.psel)
    else $error("penable without psel");

  // access phase always follows a setup phase
  aSetupFirst: assert property (@(posedge clk) disable iff (resetEdge)
    $rose(access) |-> $past(apbReq.psel && !apbReq.penable))
    else $error("apb access without setup phase");

endmodule

`default_nettype wire

// File: perfMonitorTop.sv
/* Performance monitor top */

`timescale 1ns/1ps
`default_nettype none

module perfMonitorTop (
  input  wire logic              clk,
  input  wire logic              resetEdge,
  input  perfPkg::eventVecT      events,
  input  perfPkg::branchRetireT  branchRetire,
  input  wire logic              startTrigger,
  input  wire logic              stopTrigger,
  input  perfPkg::apbReqT        apbReq,
  output perfPkg::apbRspT        apbRsp
);

  // window control to counters and trace
  perfPkg::windowCtlT  windowCtl;
  perfPkg::countT      deltas [perfPkg::NumEvents];
  // trace buffer to registers
  perfPkg::traceRecT   head;
  perfPkg::traceCountT occupancy;
  logic                overflow;
  logic                pop;
  logic                clearOverflow;

  sampleWindow window0 (
    .clk          (clk),
    .resetEdge    (resetEdge),
    .startTrigger (startTrigger),
    .stopTrigger  (stopTrigger),
    .windowCtl    (windowCtl)
  );

  eventCounters counters0 (
    .clk       (clk),
    .resetEdge (resetEdge),
    .events    (events),
    .windowCtl (windowCtl),
    .deltas    (deltas)
  );

  branchTrace trace0 (
    .clk           (clk),
    .resetEdge     (resetEdge),
    .windowCtl     (windowCtl),
    .branchRetire  (branchRetire),
    .pop           (pop),
    .clearOverflow (clearOverflow),
    .head          (head),
    .occupancy     (occupancy),
    .overflow      (overflow)
  );

  apbRegs regs0 (
    .clk           (clk),
    .resetEdge     (resetEdge),
    .apbReq        (apbReq),
    .apbRsp        (apbRsp),
    .windowOpen    (windowCtl.windowOpen),
    .deltas        (deltas),
    .head          (head),
    .occupancy     (occupancy),
    .overflow      (overflow),
    .pop           (pop),
    .clearOverflow (clearOverflow)
  );

endmodule

`default_nettype wire

// File: perfMonitorTb.sv
/* Performance monitor testbench */

`timescale 1ns/1ps
`default_nettype none

module perfMonitorTb;

  localparam string GoldenPath  = "perfMonitorGolden.txt";
  localparam int    ClkPeriodNs = 4;

  logic                  clk;
  logic                  resetEdge;
  perfPkg::eventVecT     events;
  perfPkg::branchRetireT branchRetire;
  logic                  startTrigger;
  logic                  stopTrigger;
  perfPkg::apbReqT       apbReq;
  perfPkg::apbRspT       apbRsp;

  // run bookkeeping
  string  testName;
  int     testCount;
  int     testErrors;
  int     checksDone;
  int     errorCount;
  longint limitNs;
  logic   limitReady;

  perfMonitorTop dut0 (
    .clk          (clk),
    .resetEdge    (resetEdge),
    .events       (events),
    .branchRetire (branchRetire),
    .startTrigger (startTrigger),
    .stopTrigger  (stopTrigger),
    .apbReq       (apbReq),
    .apbRsp       (apbRsp)
  );

  initial begin
    clk = 1'b0;
  end

  always #(ClkPeriodNs / 2) clk = ~clk;

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic noteError();
    errorCount++;
    testErrors++;
  endtask

  task automatic checkCount(input string what, input perfPkg::countT expected,
                            input perfPkg::countT actual);
    checksDone++;
    if (actual !== expected) begin
      noteError();
      $display("ERR %s %s expected %08h actual %08h", testName, what, expected, actual);
    end
  endtask

  // kind and taken bit of a popped record
  task automatic checkTrace(input string what, input perfPkg::traceKindT expKind,
                            input logic expTaken, input perfPkg::traceKindT actKind,
                            input logic actTaken);
    checksDone++;
    if (actKind !== expKind || actTaken !== expTaken) begin
      noteError();
      $display("ERR %s %s expected %s/%0b actual %s/%0b", testName, what,
               expKind.name(), expTaken, actKind.name(), actTaken);
    end
  endtask

  task automatic checkPc(input string what, input perfPkg::pcT expected,
                         input perfPkg::pcT actual);
    checksDone++;
    if (actual !== expected) begin
      noteError();
      $display("ERR %s %s expected pc %08h actual pc %08h", testName, what, expected, actual);
    end
  endtask

  task automatic checkErr(input string what, input logic expected, input logic actual);
    checksDone++;
    if (actual !== expected) begin
      noteError();
      $display("ERR %s %s expected pslverr %0b actual pslverr %0b", testName, what,
               expected, actual);
    end
  endtask

  //////////////////////////////
  // drivers
  //////////////////////////////

  // one cycle per loop pass, pc advances by pcInc each cycle
  task automatic driveStep(input int cycles, input perfPkg::eventVecT ev, input logic st,
                           input logic sp, input logic valid, input logic taken,
                           input perfPkg::pcT pcBase, input perfPkg::pcT pcInc);
    for (int k = 0; k < cycles; k++) begin
      @(negedge clk);
      events             = ev;
      startTrigger       = st;
      stopTrigger        = sp;
      branchRetire.valid = valid;
      branchRetire.taken = taken;
      branchRetire.pc    = pcBase + pcInc * perfPkg::pcT'(k);
    end
  endtask

  // setup, access, then one idle cycle
  task automatic apbAccess(input logic write, input perfPkg::apbAddrT addr,
                           input perfPkg::apbDataT wdata, output perfPkg::apbDataT rdata,
                           output logic err);
    @(negedge clk);
    apbReq.psel    = 1'b1;
    apbReq.penable = 1'b0;
    apbReq.pwrite  = write;
    apbReq.paddr   = addr;
    apbReq.pwdata  = wdata;
    @(negedge clk);
    apbReq.penable = 1'b1;
    #1;
    // no wait states, the access completes in this cycle
    if (apbRsp.pready !== 1'b1) begin
      noteError();
      $display("ERR %s pready at %02h expected 1 actual %0b", testName, addr, apbRsp.pready);
    end
    rdata = apbRsp.prdata;
    err   = apbRsp.pslverr;
    @(negedge clk);
    apbReq = '0;
  endtask

  // repeated access, data check picked by address
  task automatic accessCheck(input logic write, input int rep, input int addr,
                             input int data, input int expErr);
    perfPkg::apbDataT rdata;
    logic             err;
    string            what;
    for (int r = 0; r < rep; r++) begin
      what = $sformatf("%s %02h #%0d", write ? "write" : "read", addr[7:0], r);
      apbAccess(write, perfPkg::apbAddrT'(addr), perfPkg::apbDataT'(data), rdata, err);
      checkErr(what, expErr[0], err);
      if (!write) begin
        case (addr)
          'h04: checkTrace(what, perfPkg::traceKindT'(data[1:0]), data[2],
                           perfPkg::traceKindT'(rdata[1:0]), rdata[2]);
          'h08: checkPc(what, perfPkg::pcT'(data), perfPkg::pcT'(rdata));
          default: checkCount(what, perfPkg::countT'(data), perfPkg::countT'(rdata));
        endcase
      end
    end
  endtask

  //////////////////////////////
  // golden file
  //////////////////////////////

  // step cycles plus 50 per test, in ns, doubled
  task automatic sizeWatchdog(input int fd);
    string line;
    int    cyc;
    int    steps;
    int    sections;
    steps    = 0;
    sections = 0;
    while ($fgets(line, fd) > 0) begin
      if (line.getc(0) == "S" && $sscanf(line, "S %d", cyc) == 1) begin
        steps += cyc;
      end else if (line.getc(0) == "T") begin
        sections++;
      end
    end
    limitNs    = longint'((steps + 50 * sections) * ClkPeriodNs * 2);
    limitReady = 1'b1;
  endtask

  task automatic runLine(input string line);
    int  cyc, ev, st, sp, bv, bt, pc, pcStep;
    int  rep, addr, data, expErr;
    byte tag;
    tag = line.getc(0);
    case (tag)
      "T": begin
        void'($sscanf(line, "T %s", testName));
        testErrors = 0;
      end
      "S": begin
        void'($sscanf(line, "S %d %h %d %d %d %d %h %h", cyc, ev, st, sp, bv, bt, pc, pcStep));
        driveStep(cyc, perfPkg::eventVecT'(ev), st[0], sp[0], bv[0], bt[0],
                  perfPkg::pcT'(pc), perfPkg::pcT'(pcStep));
      end
      "R": begin
        void'($sscanf(line, "R %d %h %h %d", rep, addr, data, expErr));
        accessCheck(1'b0, rep, addr, data, expErr);
      end
      "W": begin
        void'($sscanf(line, "W %d %h %h %d", rep, addr, data, expErr));
        accessCheck(1'b1, rep, addr, data, expErr);
      end
      "E": begin
        testCount++;
        $display("test %s done, %0d errors", testName, testErrors);
      end
      "#", "\n", " ": begin
      end
      default: begin
        noteError();
        $display("golden line not understood: %s", line);
      end
    endcase
  endtask

  //////////////////////////////
  // main flow
  //////////////////////////////

  initial begin : mainFlow
    int    fd;
    string line;
    resetEdge    = 1'b1;
    events       = '0;
    branchRetire = '0;
    startTrigger = 1'b0;
    stopTrigger  = 1'b0;
    apbReq       = '0;
    testName     = "none";
    testCount    = 0;
    testErrors   = 0;
    checksDone   = 0;
    errorCount   = 0;
    limitNs      = 0;
    limitReady   = 1'b0;
    fd = $fopen(GoldenPath, "r");
    if (fd == 0) begin
      $display("cannot open the golden file %s", GoldenPath);
      $display("TEST FAILED");
      $finish;
    end else begin
      sizeWatchdog(fd);
      $fclose(fd);
      fd = $fopen(GoldenPath, "r");
      // reset for 10 cycles, released on a falling edge
      repeat (10) @(negedge clk);
      resetEdge = 1'b0;
      while ($fgets(line, fd) > 0) begin
        runLine(line);
      end
      $fclose(fd);
      $display("tests %0d, checks %0d, errors %0d", testCount, checksDone, errorCount);
      if (errorCount == 0 && testCount > 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

  // ends a stuck run
  initial begin : watchdog
    wait (limitReady);
    #(limitNs);
    $display("watchdog expired after %0d ns, test %s did not finish", limitNs, testName);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: perfMonitorGolden.txt
# T name | S cycles events start stop valid taken pc pcStep | R/W count addr data pslverr | E
# cycles and count are decimal, events, addr, data, pc and pcStep are hex
T trainPop
S 2 00 0 0 0 0 00000000 0
R 1 04 00000000 0
R 1 00 00000000 0
E
T deltaWindow
S 1 05 1 0 0 0 00000000 0
S 6 01 0 0 0 0 00000000 0
S 1 00 0 0 0 0 00000000 0
R 1 00 00000101 0
S 1 03 0 1 0 0 00000000 0
S 2 00 0 0 0 0 00000000 0
R 1 40 00000007 0
R 1 44 00000000 0
R 1 48 00000001 0
R 1 5c 00000000 0
R 1 00 00000200 0
R 1 04 00000001 0
R 1 04 00000003 0
E
T branchTrace
S 1 00 0 0 1 1 00001000 0
S 1 00 1 0 0 0 00000000 0
S 1 00 0 0 1 1 00003000 0
S 1 00 0 0 0 0 00000000 0
S 1 00 0 0 1 0 00003010 0
S 1 00 0 0 1 1 00003020 0
S 1 00 0 1 0 0 00000000 0
S 1 00 0 0 1 1 00004000 0
S 2 00 0 0 0 0 00000000 0
R 1 00 00000500 0
R 1 04 00000001 0
R 1 08 00003000 0
R 1 04 00000006 0
R 1 08 00003010 0
R 1 04 00000002 0
R 1 08 00003020 0
R 1 04 00000006 0
R 1 04 00000003 0
R 1 00 00000000 0
E
T overflow
S 1 00 1 0 0 0 00000000 0
S 20 00 0 0 1 1 0000a000 4
S 1 00 0 1 0 0 00000000 0
S 2 00 0 0 0 0 00000000 0
R 1 00 00001002 0
R 1 04 00000001 0
R 1 08 0000a000 0
W 1 00 00000002 0
R 1 00 00000f00 0
R 14 04 00000006 0
R 1 08 0000a038 0
R 1 04 00000006 0
R 1 00 00000000 0
E
T errors
S 2 00 0 0 0 0 00000000 0
R 1 00 00000000 0
R 1 0c 00000000 1
R 1 60 00000000 1
W 1 04 00000001 1
R 1 04 00000000 1
R 1 08 00000000 1
R 1 00 00000000 0
E

// File: verilog.f
perfPkg.sv
sampleWindow.sv
eventCounters.sv
branchTrace.sv
apbRegs.sv
perfMonitorTop.sv
perfMonitorTb.sv

// File: Makefile
# Verilator build and run for the performance monitor
TOP := perfMonitorTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f verilog.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
